// File: logic/am_pkg.sv
package am_pkg;

  // Operand and product sizes. All other widths follow from OP_W.
  localparam int OP_W = 24;
  localparam int PROD_W = 2 * OP_W;

  // The sum and carry vectors of a carry-save row are one bit narrower than an operand.
  localparam int SUM_W = OP_W - 1;

  // Adder rows that follow partial product 0.
  localparam int ROW_COUNT = OP_W - 1;

  typedef logic [OP_W-1:0] operand_t;
  typedef logic [PROD_W-1:0] product_t;

  // Carry-save state passed from each pipeline stage to the next.
  typedef struct packed {
    operand_t         a;        // Multiplicand.
    operand_t         b;        // Multiplier.
    logic [SUM_W-1:0] sum;      // Sum of the last row; its bit 0 is already retired.
    logic [SUM_W-1:0] carry;    // Carries of the last row.
    logic             top;      // Top bit of the last partial product.
    operand_t         prod_lo;  // Low product bits retired so far.
  } mul_state_t;

  // One row of the AND-gate array.
  function automatic operand_t partial_product(
    input operand_t a,
    input logic     b_bit
  );
    return a & {OP_W{b_bit}};
  endfunction

endpackage

// File: logic/pp_init_stage.sv
module pp_init_stage
  import am_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  operand_t   a,
  input  operand_t   b,
  output mul_state_t state
);

  operand_t   pp0;
  mul_state_t state_d;

  assign pp0 = partial_product(a, b[0]);  // Row 0 of the array.

  // Row 0 has nothing to add yet, so it is the first carry-save state as it stands.
  always_comb begin
    state_d         = '0;
    state_d.a       = a;
    state_d.b       = b;
    state_d.sum     = pp0[SUM_W-1:0];        // Bit 0 doubles as product bit 0.
    state_d.carry   = '0;                    // Makes row 1 a row of half adders.
    state_d.top     = pp0[OP_W-1];
    state_d.prod_lo = operand_t'(pp0[0]);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= '0;
    end else begin
      state <= state_d;
    end
  end

endmodule

// File: logic/csa_row_stage.sv
module csa_row_stage
  import am_pkg::*;
#(
  parameter int FIRST_ROW = 1,
  parameter int ROW_COUNT_HERE = 1
) (
  input  logic       clk,
  input  logic       arst_n,
  input  mul_state_t state_in,
  output mul_state_t state_out
);

  mul_state_t state_d;

  // Each row adds partial product k to the shifted sum of the row above.
  // Position i of row k sees sum bit i+1, except the top position, which
  // takes the top bit of the previous partial product instead.
  always_comb begin : row_chain
    mul_state_t       st;
    operand_t         pp;
    logic [SUM_W-1:0] x;
    logic [SUM_W-1:0] pp_lo;
    logic [SUM_W-1:0] s_row;
    logic [SUM_W-1:0] c_row;

    st    = state_in;
    pp    = '0;
    x     = '0;
    pp_lo = '0;
    s_row = '0;
    c_row = '0;

    for (int r = 0; r < ROW_COUNT_HERE; r++) begin
      pp    = partial_product(st.a, st.b[FIRST_ROW + r]);
      pp_lo = pp[SUM_W-1:0];
      x     = {st.top, st.sum[SUM_W-1:1]};        // Shifted row sum with the old top bit.

      // One full adder per bit position.
      s_row = x ^ st.carry ^ pp_lo;
      c_row = (x & st.carry) | (x & pp_lo) | (st.carry & pp_lo);

      st.sum   = s_row;
      st.carry = c_row;
      st.top   = pp[OP_W-1];                      // Feeds the top position of the next row.
      st.prod_lo[FIRST_ROW + r] = s_row[0];       // The lowest sum bit is final now.
    end

    state_d = st;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_out <= '0;
    end else begin
      state_out <= state_d;
    end
  end

endmodule

// File: logic/cpa_stage.sv
module cpa_stage
  import am_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  mul_state_t state,
  output product_t   product
);

  operand_t sum_word;
  operand_t carry_word;
  operand_t upper;

  // The carry vector already sits one place left of the sum bits.
  assign sum_word   = {1'b0, state.top, state.sum[SUM_W-1:1]};
  assign carry_word = {1'b0, state.carry};

  // Ripple-carry adder for the upper half of the product.
  always_comb begin : ripple
    logic cy;

    cy = 1'b0;
    for (int i = 0; i < OP_W; i++) begin
      upper[i] = sum_word[i] ^ carry_word[i] ^ cy;
      cy = (sum_word[i] & carry_word[i]) | (cy & (sum_word[i] ^ carry_word[i]));
    end
  end  // The carry out of bit 23 is always zero for a 24 x 24 product.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      product <= '0;
    end else begin
      product <= {upper, state.prod_lo};
    end
  end

endmodule

// File: logic/am_mult_top.sv
module am_mult_top
  import am_pkg::*;
#(
  parameter int ROWS_PER_STAGE = 6
) (
  input  logic     clk,
  input  logic     arst_n,
  input  operand_t a,
  input  operand_t b,
  output product_t product
);

  // Row stages needed to cover all adder rows, rounded up.
  localparam int NUM_ROW_STAGES = (ROW_COUNT + ROWS_PER_STAGE - 1) / ROWS_PER_STAGE;

  // Entry 0 comes from the input stage, entry g+1 from row stage g.
  mul_state_t stage_state [NUM_ROW_STAGES+1];

  if (ROWS_PER_STAGE < 1 || ROWS_PER_STAGE > ROW_COUNT) begin : g_bad_rows
    $error("ROWS_PER_STAGE must lie between 1 and %0d.", ROW_COUNT);
  end

  pp_init_stage pp_init_i (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (a),
    .b      (b),
    .state  (stage_state[0])
  );

  for (genvar g = 0; g < NUM_ROW_STAGES; g++) begin : g_row
    localparam int FIRST = 1 + g * ROWS_PER_STAGE;          // Row index handled first here.
    localparam int LEFT = ROW_COUNT + 1 - FIRST;            // Rows still open at this stage.
    localparam int COUNT = (LEFT < ROWS_PER_STAGE) ? LEFT : ROWS_PER_STAGE;

    csa_row_stage #(
      .FIRST_ROW      (FIRST),
      .ROW_COUNT_HERE (COUNT)
    ) row_stage_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .state_in  (stage_state[g]),
      .state_out (stage_state[g+1])
    );
  end

  cpa_stage cpa_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .state   (stage_state[NUM_ROW_STAGES]),
    .product (product)
  );

endmodule

// File: sim/am_mult_checker.sv
module am_mult_checker
  import am_pkg::*;
#(
  parameter int ROWS_PER_STAGE = 6
) (
  input logic     clk,
  input logic     arst_n,
  input operand_t a,
  input operand_t b,
  input product_t product
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LATENCY = (ROW_COUNT + ROWS_PER_STAGE - 1) / ROWS_PER_STAGE + 2;

  int cycles_out_of_reset;

  // Saturates once the pipeline holds only sampled operands.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycles_out_of_reset <= 0;
    end else if (cycles_out_of_reset <= LATENCY) begin
      cycles_out_of_reset <= cycles_out_of_reset + 1;
    end
  end

  reset_zero_a : assert property (@(posedge clk) !arst_n |-> product == '0)
    else $error("product is not zero while reset is active.");

  result_a : assert property (@(posedge clk) disable iff (!arst_n)
    (cycles_out_of_reset > LATENCY) |->
      product == product_t'($past(a, LATENCY)) * product_t'($past(b, LATENCY)))
    else $error("product does not match the operands sampled %0d cycles earlier.", LATENCY);

  known_a : assert property (@(posedge clk) disable iff (!arst_n)
    (cycles_out_of_reset > LATENCY) |-> !$isunknown(product))
    else $error("product has unknown bits.");

endmodule

bind am_mult_top am_mult_checker #(
  .ROWS_PER_STAGE (ROWS_PER_STAGE)
) checker_i (
  .clk     (clk),
  .arst_n  (arst_n),
  .a       (a),
  .b       (b),
  .product (product)
);

// File: sim/am_mult_tb.sv
module am_mult_tb
  import am_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ROWS_PER_STAGE = 6;
  localparam int NUM_ROW_STAGES = (ROW_COUNT + ROWS_PER_STAGE - 1) / ROWS_PER_STAGE;
  localparam int LATENCY = NUM_ROW_STAGES + 2;  // Input stage, row stages and final adder.
  localparam int RESET_CYCLES = 16;
  localparam int N_VEC = 20;
  localparam int N_RANDOM = 200;
  localparam logic [15:0] LFSR_SEED = 16'd68;

  // One line of the directed table.
  typedef struct packed {
    operand_t    a;
    operand_t    b;
    product_t    p;
    logic [7:0]  hold;  // Cycles the pair is held at the inputs.
  } vec_t;

  // One product in flight, kept with its operands for the error line.
  typedef struct packed {
    operand_t a;
    operand_t b;
    product_t p;
  } expect_t;

  logic     clk;
  logic     arst_n;
  operand_t a;
  operand_t b;
  product_t product;

  vec_t        vectors [N_VEC];
  expect_t     exp_q [$];
  logic [15:0] lfsr;
  int          table_cycles;
  logic        table_ready;
  int          checks;
  int          errors;

  am_mult_top #(
    .ROWS_PER_STAGE (ROWS_PER_STAGE)
  ) dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .a       (a),
    .b       (b),
    .product (product)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Columns are a, b, expected product, cycles held.
  task automatic load_vectors();
    vectors[0]  = '{24'h000000, 24'h000000, 48'h000000000000, 8'd2};
    vectors[1]  = '{24'h000000, 24'hFFFFFF, 48'h000000000000, 8'd1};
    vectors[2]  = '{24'hFFFFFF, 24'h000000, 48'h000000000000, 8'd1};
    vectors[3]  = '{24'h000001, 24'h000001, 48'h000000000001, 8'd1};
    vectors[4]  = '{24'hFFFFFF, 24'h000001, 48'h000000FFFFFF, 8'd1};
    vectors[5]  = '{24'h000001, 24'hFFFFFF, 48'h000000FFFFFF, 8'd1};
    vectors[6]  = '{24'h123456, 24'h000001, 48'h000000123456, 8'd1};
    vectors[7]  = '{24'h000001, 24'h654321, 48'h000000654321, 8'd1};
    vectors[8]  = '{24'hFFFFFF, 24'hFFFFFF, 48'hFFFFFE000001, 8'd3};
    vectors[9]  = '{24'h800000, 24'h800000, 48'h400000000000, 8'd1};
    vectors[10] = '{24'h800000, 24'h000002, 48'h000001000000, 8'd1};
    vectors[11] = '{24'h000400, 24'h004000, 48'h000001000000, 8'd1};
    vectors[12] = '{24'h800000, 24'hFFFFFF, 48'h7FFFFF800000, 8'd1};
    vectors[13] = '{24'hFFFFFF, 24'h800000, 48'h7FFFFF800000, 8'd1};
    vectors[14] = '{24'hAAAAAA, 24'hFFFFFF, 48'hAAAAA9555556, 8'd1};
    vectors[15] = '{24'h555555, 24'hFFFFFF, 48'h555554AAAAAB, 8'd1};
    vectors[16] = '{24'h555555, 24'h555555, 48'h1C71C6E38E39, 8'd1};
    vectors[17] = '{24'hAAAAAA, 24'h555555, 48'h38E38DC71C72, 8'd1};
    vectors[18] = '{24'hAAAAAA, 24'hAAAAAA, 48'h71C71B8E38E4, 8'd2};
    vectors[19] = '{24'h00ABCD, 24'h000100, 48'h000000ABCD00, 8'd4};
  endtask

  function automatic int count_table_cycles();
    int total;

    total = 0;
    for (int i = 0; i < N_VEC; i++) begin
      total += int'(vectors[i].hold);
    end
    return total;
  endfunction

  // Fibonacci LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_operand(output operand_t v);
    for (int i = 0; i < OP_W; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic check_reset_zero();
    checks++;
    assert (product === '0) else begin
      errors++;
      $display("** Error: product during reset expected %h, actual %h", product_t'(0), product);
    end
  endtask

  task automatic check_front();
    expect_t e;

    e = exp_q.pop_front();
    checks++;
    assert (product === e.p) else begin
      errors++;
      $display("** Error: product for a=%h b=%h expected %h, actual %h",
               e.a, e.b, e.p, product);
    end
  endtask

  // The result due now is checked before the next pair goes in.
  task automatic apply_pair(input operand_t x, input operand_t y, input product_t expected);
    expect_t e;

    @(negedge clk);
    check_front();
    a = x;
    b = y;
    e.a = x;
    e.b = y;
    e.p = expected;
    exp_q.push_back(e);
  endtask

  initial begin : main
    operand_t x;
    operand_t y;

    arst_n = 1'b0;
    a = '0;
    b = '0;
    lfsr = LFSR_SEED;
    checks = 0;
    errors = 0;
    table_ready = 1'b0;
    load_vectors();
    table_cycles = count_table_cycles();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_zero();
    end
    arst_n = 1'b1;

    // Zero operands fill the pipeline until the first pair comes out.
    repeat (LATENCY) exp_q.push_back('0);

    for (int i = 0; i < N_VEC; i++) begin
      for (int k = 0; k < int'(vectors[i].hold); k++) begin
        apply_pair(vectors[i].a, vectors[i].b, vectors[i].p);
      end
    end

    for (int n = 0; n < N_RANDOM; n++) begin
      random_operand(x);
      random_operand(y);
      apply_pair(x, y, product_t'(x) * product_t'(y));
    end

    repeat (LATENCY) begin
      @(negedge clk);
      check_front();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;

    wait (table_ready);
    limit = table_cycles + N_RANDOM + LATENCY + RESET_CYCLES + 20;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles.", limit);
    $display("sim failed");
    $finish;
  end

endmodule

// File: all.f
logic/am_pkg.sv
logic/pp_init_stage.sv
logic/csa_row_stage.sv
logic/cpa_stage.sv
logic/am_mult_top.sv
sim/am_mult_checker.sv
sim/am_mult_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot change to the project directory."
  exit 1
fi

rm -rf obj_dir
if [ $? -ne 0 ]; then
  echo "Cannot remove the old build directory."
  exit 1
fi

verilator --binary --timing --assert \
  --top-module am_mult_tb \
  -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

sim_output=$(./obj_dir/Vam_mult_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

# The run counts as good only when the testbench printed its pass line.
if printf '%s\n' "$sim_output" | grep -qx "sim passed"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi
